//--- Bender.yml
package:
  name: tcb_lite_mem

sources:
  # synthesizable memory, package first
  - files:
      - design/tcb_mem_pkg.sv
      - design/tcb_port_align.sv
      - design/tcb_byte_bank.sv
      - design/tcb_lite_mem.sv

  # simulation only
  - target: test
    files:
      - bench/tcb_mem_clk.sv
      - bench/tcb_mem_tb.sv

//--- bench/tcb_mem_clk.sv
// module tcb_mem_clk: free-running bus clock and power-on reset for the testbench
module tcb_mem_clk #(
    // clock period in time units
    parameter int unsigned PERIOD     = 20,
    // clock cycles with reset held low
    parameter int unsigned RST_CYCLES = 8
) (
    output logic tcb,
    output logic rst_n
);

    // first rising edge at half a period
    initial begin
        tcb = 1'b0;
        forever #(PERIOD / 2) tcb = ~tcb;
    end

    // release on a rising edge, like a synchronized reset would
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge tcb);
        rst_n <= 1'b1;
    end

endmodule : tcb_mem_clk

//--- bench/tcb_mem_golden.txt
# name chain | p0: vld wen adr siz byt wdt | p1: vld wen adr siz byt wdt | p0_rdt p0_err p1_rdt p1_err
# all values hex, expected response is the one seen one cycle after the line
# chain 1 means the next line follows in the very next cycle
# port 0 is size mode with writes allowed, port 1 is byte-enable mode with writes denied
rst_idle    0  0 0 00 0 0 00000000  0 0 00 0 0 00000000  00000000 0 00000000 0
w_word_00   0  1 1 00 2 0 44332211  0 0 00 0 0 00000000  00000000 0 00000000 0
r_word_00   0  1 0 00 2 0 00000000  0 0 00 0 0 00000000  44332211 0 00000000 0
w_byte_05   0  1 1 05 0 0 000000a5  0 0 00 0 0 00000000  44332211 0 00000000 0
r_byte_05   0  1 0 05 0 0 00000000  0 0 00 0 0 00000000  000000a5 0 00000000 0
w_half_0a   0  1 1 0a 1 0 0000beef  0 0 00 0 0 00000000  000000a5 0 00000000 0
r_half_0a   0  1 0 0a 1 0 00000000  0 0 00 0 0 00000000  0000beef 0 00000000 0
w_half_07   0  1 1 07 1 0 00001357  0 0 00 0 0 00000000  0000beef 0 00000000 0
r_half_07   0  1 0 07 1 0 00000000  0 0 00 0 0 00000000  00001357 0 00000000 0
w_word_0d   0  1 1 0d 2 0 88776655  0 0 00 0 0 00000000  00001357 0 00000000 0
r_word_0d   0  1 0 0d 2 0 00000000  0 0 00 0 0 00000000  88776655 0 00000000 0
w_word_ff   0  1 1 ff 2 0 ddccbbaa  0 0 00 0 0 00000000  88776655 0 00000000 0
r_word_ff   0  1 0 ff 2 0 00000000  0 0 00 0 0 00000000  ddccbbaa 0 00000000 0
r_word_00b  0  1 0 00 2 0 00000000  0 0 00 0 0 00000000  44ddccbb 0 00000000 0
r_byte_03   0  1 0 03 0 0 00000000  0 0 00 0 0 00000000  00000044 0 00000000 0
r_half_0f   0  1 0 0f 1 0 00000000  0 0 00 0 0 00000000  00008877 0 00000000 0
r_byte_ff   0  1 0 ff 0 0 00000000  0 0 00 0 0 00000000  000000aa 0 00000000 0
r_half_ff   0  1 0 ff 1 0 00000000  0 0 00 0 0 00000000  0000bbaa 0 00000000 0
r_byte_0a   0  1 0 0a 0 0 00000000  0 0 00 0 0 00000000  000000ef 0 00000000 0
r_half_0d   0  1 0 0d 1 0 00000000  0 0 00 0 0 00000000  00006655 0 00000000 0
w_word_04   0  1 1 04 2 0 7b6a5948  0 0 00 0 0 00000000  00006655 0 00000000 0
w_word_08   0  1 1 08 2 0 c3b2a190  0 0 00 0 0 00000000  00006655 0 00000000 0
be_rd_04_f  0  0 0 00 0 0 00000000  1 0 04 0 f 00000000  00006655 0 7b6a5948 0
be_rd_04_5  0  0 0 00 0 0 00000000  1 0 04 0 5 00000000  00006655 0 006a0048 0
be_rd_08_a  0  0 0 00 0 0 00000000  1 0 08 0 a 00000000  00006655 0 c300a100 0
be_rd_08_1  0  0 0 00 0 0 00000000  1 0 08 0 1 00000000  00006655 0 00000090 0
be_rd_0c_e  0  0 0 00 0 0 00000000  1 0 0c 0 e 00000000  00006655 0 77665500 0
be_rd_0e_1  0  0 0 00 0 0 00000000  1 0 0e 0 1 00000000  00006655 0 00000088 0
p1_wr_deny  0  0 0 00 0 0 00000000  1 1 04 0 f deadbeef  00006655 0 00000088 1
p1_rd_chk   0  0 0 00 0 0 00000000  1 0 04 0 f 00000000  00006655 0 7b6a5948 0
p1_wr_deny2 0  0 0 00 0 0 00000000  1 1 00 0 1 000000ee  00006655 0 7b6a5948 1
p0_rd_00    0  1 0 00 0 0 00000000  0 0 00 0 0 00000000  000000bb 0 7b6a5948 1
coll_wr_04  0  1 1 04 2 0 1f2e3d4c  1 0 04 0 f 00000000  000000bb 0 7b6a5948 0
coll_new_04 0  0 0 00 0 0 00000000  1 0 04 0 f 00000000  000000bb 0 1f2e3d4c 0
coll_wr_0a  0  1 1 0a 1 0 0000d00d  1 0 08 0 c 00000000  000000bb 0 c3b20000 0
coll_new_08 0  1 0 08 2 0 00000000  1 0 08 0 c 00000000  d00da190 0 d00d0000 0
b2b_w_20    1  1 1 20 2 0 01234567  0 0 00 0 0 00000000  d00da190 0 d00d0000 0
b2b_r_20    1  1 0 20 2 0 00000000  1 0 20 0 3 00000000  01234567 0 00004567 0
b2b_r_22    1  1 0 22 1 0 00000000  1 0 20 0 c 00000000  00000123 0 01230000 0
b2b_w_21    1  1 1 21 0 0 000000ff  1 1 20 0 f 11111111  00000123 0 01230000 1
b2b_r_20b   0  1 0 20 2 0 00000000  1 0 20 0 2 00000000  0123ff67 0 0000ff00 0
idle_end    0  0 0 00 0 0 00000000  0 0 00 0 0 00000000  0123ff67 0 0000ff00 0

//--- bench/tcb_mem_tb.sv
// module tcb_mem_tb: testbench top driving both ports from the golden file and checking responses
module tcb_mem_tb
    import tcb_mem_pkg::*;
();

    //////////////////////////////
    // configuration
    //////////////////////////////

    localparam int unsigned SIZE        = 256;
    localparam int unsigned AW          = $clog2(SIZE);
    // writes allowed on port 0 only
    localparam logic [1:0]  WRM         = 2'b01;
    localparam string       GOLDEN      = "bench/tcb_mem_golden.txt";
    localparam int          MAX_TESTS   = 64;
    localparam int          MAX_LINES   = 256;
    localparam int          RST_TIMEOUT = 100;
    localparam logic [31:0] SEED        = 32'h389c_d132;

    // clock, reset and DUT ports
    logic           tcb;
    logic           rst_n;
    logic           p0_vld, p1_vld;
    logic           p0_wen, p1_wen;
    logic [AW-1:0]  p0_adr, p1_adr;
    tcb_siz_t       p0_siz, p1_siz;
    logic [BYT-1:0] p0_byt, p1_byt;
    logic [DW-1:0]  p0_wdt, p1_wdt;
    logic [DW-1:0]  p0_rdt, p1_rdt;
    logic           p0_err, p1_err;

    // golden table, second index is the port number
    string          t_name  [MAX_TESTS];
    logic           t_chain [MAX_TESTS];
    logic           t_vld   [MAX_TESTS][2];
    logic           t_wen   [MAX_TESTS][2];
    logic [AW-1:0]  t_adr   [MAX_TESTS][2];
    logic [1:0]     t_siz   [MAX_TESTS][2];
    logic [BYT-1:0] t_byt   [MAX_TESTS][2];
    logic [DW-1:0]  t_wdt   [MAX_TESTS][2];
    logic [DW-1:0]  t_rdt   [MAX_TESTS][2];
    logic           t_err   [MAX_TESTS][2];

    // bookkeeping
    int          n_tests;
    int          n_checks;
    int          errors;
    bit          setup_ok;
    bit          test_bad;
    logic [31:0] lfsr;

    tcb_mem_clk #(.PERIOD(20), .RST_CYCLES(8)) clk_gen (.tcb(tcb), .rst_n(rst_n));

    tcb_lite_mem #(
        .SIZE(SIZE), .AW(AW), .WRM(WRM), .MOD0(MODE_LOG_SIZE), .MOD1(MODE_BYTE_ENA)
    ) uut (
        .tcb(tcb), .rst_n(rst_n),
        .p0_vld(p0_vld), .p0_wen(p0_wen), .p0_adr(p0_adr), .p0_siz(p0_siz),
        .p0_byt(p0_byt), .p0_wdt(p0_wdt), .p0_rdt(p0_rdt), .p0_err(p0_err),
        .p1_vld(p1_vld), .p1_wen(p1_wen), .p1_adr(p1_adr), .p1_siz(p1_siz),
        .p1_byt(p1_byt), .p1_wdt(p1_wdt), .p1_rdt(p1_rdt), .p1_err(p1_err)
    );

    //////////////////////////////
    // helpers
    //////////////////////////////

    // fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // 0 to 3 idle cycles, one LFSR step per bit
    function automatic int pick_idle();
        int n;
        n = 0;
        for (int k = 0; k < 2; k++) begin
            lfsr = lfsr_next(lfsr);
            n = (n << 1) | int'(lfsr[0]);
        end
        return n;
    endfunction

    task automatic load_golden();
        int    fd;
        int    n_lines;
        int    n_fields;
        string line;
        fd = $fopen(GOLDEN, "r");
        if (fd == 0) begin
            $display("cannot open the golden file %0s", GOLDEN);
            errors++;
            setup_ok = 1'b0;
        end else begin
            n_lines = 0;
            // bounded by a line limit, a broken file cannot keep us here
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                n_lines++;
                line = "";
                void'($fgets(line, fd));
                // comment and empty lines carry no test
                if (line.len() > 1 && line[0] != "#") begin
                    if (n_tests >= MAX_TESTS) begin
                        $display("golden file holds more than %0d tests", MAX_TESTS);
                        errors++;
                        setup_ok = 1'b0;
                    end else begin
                        n_fields = $sscanf(line,
                            "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            t_name[n_tests], t_chain[n_tests],
                            t_vld[n_tests][0], t_wen[n_tests][0], t_adr[n_tests][0],
                            t_siz[n_tests][0], t_byt[n_tests][0], t_wdt[n_tests][0],
                            t_vld[n_tests][1], t_wen[n_tests][1], t_adr[n_tests][1],
                            t_siz[n_tests][1], t_byt[n_tests][1], t_wdt[n_tests][1],
                            t_rdt[n_tests][0], t_err[n_tests][0],
                            t_rdt[n_tests][1], t_err[n_tests][1]);
                        if (n_fields != 18) begin
                            $display("golden file line %0d is malformed", n_lines);
                            errors++;
                            setup_ok = 1'b0;
                        end else begin
                            n_tests++;
                        end
                    end
                end
            end
            if (!$feof(fd)) begin
                $display("golden file read gave up after %0d lines", MAX_LINES);
                errors++;
                setup_ok = 1'b0;
            end
            $fclose(fd);
            if (n_tests == 0) begin
                $display("golden file holds no tests");
                errors++;
                setup_ok = 1'b0;
            end
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        // sample on the falling edge, reset lets go on a rising one
        while (rst_n !== 1'b1 && n < RST_TIMEOUT) begin
            @(negedge tcb);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset still active after %0d cycles", RST_TIMEOUT);
            errors++;
            setup_ok = 1'b0;
        end
    endtask

    task automatic drive_idle();
        p0_vld <= 1'b0;
        p0_wen <= 1'b0;
        p1_vld <= 1'b0;
        p1_wen <= 1'b0;
    endtask

    // past the last test the ports go idle
    task automatic drive_line(input int idx);
        if (idx >= n_tests) begin
            drive_idle();
        end else begin
            p0_vld <= t_vld[idx][0];
            p0_wen <= t_wen[idx][0];
            p0_adr <= t_adr[idx][0];
            p0_siz <= tcb_siz_t'(t_siz[idx][0]);
            p0_byt <= t_byt[idx][0];
            p0_wdt <= t_wdt[idx][0];
            p1_vld <= t_vld[idx][1];
            p1_wen <= t_wen[idx][1];
            p1_adr <= t_adr[idx][1];
            p1_siz <= tcb_siz_t'(t_siz[idx][1]);
            p1_byt <= t_byt[idx][1];
            p1_wdt <= t_wdt[idx][1];
        end
    endtask

    task automatic compare_value(input string test, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        assert (act === exp) else begin
            $display("[ERROR] %0s %0s expected %h actual %h", test, what, exp, act);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_response(input int idx, input string when);
        compare_value(t_name[idx], {"p0_rdt", when}, t_rdt[idx][0], p0_rdt);
        compare_value(t_name[idx], {"p0_err", when}, 32'(t_err[idx][0]), 32'(p0_err));
        compare_value(t_name[idx], {"p1_rdt", when}, t_rdt[idx][1], p1_rdt);
        compare_value(t_name[idx], {"p1_err", when}, 32'(t_err[idx][1]), 32'(p1_err));
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    task automatic run_tests();
        int idle;
        int i;
        int j;
        @(posedge tcb);
        drive_line(0);
        for (i = 0; i < n_tests; i++) begin
            test_bad = 1'b0;
            // transfer of line i is taken at this edge
            @(posedge tcb);
            idle = t_chain[i] ? 0 : pick_idle();
            if (idle == 0) begin
                drive_line(i + 1);
            end else begin
                drive_idle();
            end
            @(negedge tcb);
            check_response(i, "");
            // response must hold through the gap
            for (j = 1; j <= idle; j++) begin
                @(posedge tcb);
                if (j == idle) begin
                    drive_line(i + 1);
                end
                @(negedge tcb);
                check_response(i, $sformatf(" idle %0d", j));
            end
            $display("test %0s: %0s", t_name[i], test_bad ? "mismatch" : "match");
        end
    endtask

    initial begin
        p0_vld = 1'b0;
        p0_wen = 1'b0;
        p0_adr = '0;
        p0_siz = SIZ_BYTE;
        p0_byt = '0;
        p0_wdt = '0;
        p1_vld = 1'b0;
        p1_wen = 1'b0;
        p1_adr = '0;
        p1_siz = SIZ_BYTE;
        p1_byt = '0;
        p1_wdt = '0;
        lfsr     = SEED;
        n_tests  = 0;
        n_checks = 0;
        errors   = 0;
        setup_ok = 1'b1;
        load_golden();
        if (setup_ok) begin
            wait_reset_release();
        end
        if (setup_ok) begin
            run_tests();
        end
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, errors);
        if (setup_ok && errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : tcb_mem_tb

//--- design/tcb_byte_bank.sv
// module tcb_byte_bank: two-port byte-lane storage, write priority, permission and read capture
module tcb_byte_bank import tcb_mem_pkg::*; #(
    // memory size in bytes, power of two
    parameter int unsigned SIZE = 256,
    // byte address width
    parameter int unsigned AW   = $clog2(SIZE),
    // write permission, bit N allows writes from port N
    parameter logic [1:0]  WRM  = 2'b11
) (
    input  logic                          tcb,
    input  logic                          rst_n,
    // port 0 lane request and response
    input  logic                          p0_req,
    input  logic                          p0_wen,
    input  logic [BYT-1:0]                p0_lane_en,
    input  logic [BYT-1:0][AW-LANE_W-1:0] p0_lane_row,
    input  logic [BYT-1:0][BW-1:0]        p0_lane_wdt,
    output logic [BYT-1:0][BW-1:0]        p0_lane_rdt,
    output logic                          p0_err,
    // port 1 lane request and response
    input  logic                          p1_req,
    input  logic                          p1_wen,
    input  logic [BYT-1:0]                p1_lane_en,
    input  logic [BYT-1:0][AW-LANE_W-1:0] p1_lane_row,
    input  logic [BYT-1:0][BW-1:0]        p1_lane_wdt,
    output logic [BYT-1:0][BW-1:0]        p1_lane_rdt,
    output logic                          p1_err
);

    // rows per lane and row address width
    localparam int unsigned ROWS = SIZE / BYT;
    localparam int unsigned RW   = AW - LANE_W;
    // number of ports
    localparam int unsigned PN   = 2;

    // both ports side by side, index is the port number
    logic [PN-1:0]                  req;
    logic [PN-1:0]                  wen;
    logic [PN-1:0][BYT-1:0]         en;
    logic [PN-1:0][BYT-1:0][RW-1:0] row;
    logic [PN-1:0][BYT-1:0][BW-1:0] wdt;
    logic [PN-1:0][BYT-1:0][BW-1:0] rdt;
    logic [PN-1:0]                  err;

    // lane write strobes after the permission mask
    logic [PN-1:0][BYT-1:0]         we;

    // one byte column per lane
    logic [BW-1:0] mem [BYT][ROWS];

    assign req = {p1_req, p0_req};
    assign wen = {p1_wen, p0_wen};
    assign en  = {p1_lane_en, p0_lane_en};
    assign row = {p1_lane_row, p0_lane_row};
    assign wdt = {p1_lane_wdt, p0_lane_wdt};

    assign p0_lane_rdt = rdt[0];
    assign p1_lane_rdt = rdt[1];
    assign p0_err      = err[0];
    assign p1_err      = err[1];

    //////////////////////////////
    // write
    //////////////////////////////

    always_comb begin
        for (int p = 0; p < PN; p++) begin
            we[p] = (req[p] && wen[p] && WRM[p]) ? en[p] : '0;
        end
    end

    // port 1 is applied last, so it wins on the same byte
    always_ff @(posedge tcb) begin
        for (int l = 0; l < BYT; l++) begin
            for (int p = 0; p < PN; p++) begin
                if (we[p][l]) begin
                    mem[l][row[p][l]] <= wdt[p][l];
                end
            end
        end
    end

    //////////////////////////////
    // read and error response
    //////////////////////////////

    // sampled at the same edge as the write, so old data comes back
    always_ff @(posedge tcb or negedge rst_n) begin
        if (!rst_n) begin
            rdt <= '0;
            err <= '0;
        end else begin
            for (int p = 0; p < PN; p++) begin
                for (int l = 0; l < BYT; l++) begin
                    if (req[p] && !wen[p] && en[p][l]) begin
                        rdt[p][l] <= mem[l][row[p][l]];
                    end
                end
                // err follows each transfer and holds until the next one
                if (req[p]) begin
                    err[p] <= wen[p] && !WRM[p];
                end
            end
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    for (genvar p = 0; p < PN; p++) begin : g_chk
        // transfer strobe stays clean once out of reset
        req_known: assert property (
            @(posedge tcb) disable iff (!rst_n)
            !$isunknown(req[p])
        ) else $error("port %0d request strobe unknown", p);
        // an error response only ever answers a denied write
        err_cause: assert property (
            @(posedge tcb) disable iff (!rst_n)
            $rose(err[p]) |-> ($past(req[p] && wen[p]) && !WRM[p])
        ) else $error("port %0d error without a denied write", p);
    end

endmodule : tcb_byte_bank

//--- design/tcb_lite_mem.sv
// module tcb_lite_mem: two TCB-Lite ports, one aligner each, sharing a byte-lane bank
module tcb_lite_mem import tcb_mem_pkg::*; #(
    // memory size in bytes, power of two
    parameter int unsigned SIZE = 256,
    // byte address width
    parameter int unsigned AW   = $clog2(SIZE),
    // write permission per port
    parameter logic [1:0]  WRM  = 2'b11,
    // addressing mode per port
    parameter tcb_mode_t   MOD0 = MODE_LOG_SIZE,
    parameter tcb_mode_t   MOD1 = MODE_BYTE_ENA
) (
    input  logic           tcb,
    input  logic           rst_n,
    // port 0
    input  logic           p0_vld,
    input  logic           p0_wen,
    input  logic [AW-1:0]  p0_adr,
    input  tcb_siz_t       p0_siz,
    input  logic [BYT-1:0] p0_byt,
    input  logic [DW-1:0]  p0_wdt,
    output logic [DW-1:0]  p0_rdt,
    output logic           p0_err,
    // port 1
    input  logic           p1_vld,
    input  logic           p1_wen,
    input  logic [AW-1:0]  p1_adr,
    input  tcb_siz_t       p1_siz,
    input  logic [BYT-1:0] p1_byt,
    input  logic [DW-1:0]  p1_wdt,
    output logic [DW-1:0]  p1_rdt,
    output logic           p1_err
);

    // port 0 lane request and read bytes
    logic                          p0_req;
    logic                          p0_lwen;
    logic [BYT-1:0]                p0_lane_en;
    logic [BYT-1:0][AW-LANE_W-1:0] p0_lane_row;
    logic [BYT-1:0][BW-1:0]        p0_lane_wdt;
    logic [BYT-1:0][BW-1:0]        p0_lane_rdt;
    // port 1 lane request and read bytes
    logic                          p1_req;
    logic                          p1_lwen;
    logic [BYT-1:0]                p1_lane_en;
    logic [BYT-1:0][AW-LANE_W-1:0] p1_lane_row;
    logic [BYT-1:0][BW-1:0]        p1_lane_wdt;
    logic [BYT-1:0][BW-1:0]        p1_lane_rdt;

    tcb_port_align #(.MOD(MOD0), .AW(AW)) align0 (
        .tcb(tcb), .rst_n(rst_n),
        .vld(p0_vld), .wen(p0_wen), .adr(p0_adr), .siz(p0_siz), .byt(p0_byt), .wdt(p0_wdt),
        .rdt(p0_rdt),
        .req(p0_req), .wen_o(p0_lwen), .lane_en(p0_lane_en), .lane_row(p0_lane_row),
        .lane_wdt(p0_lane_wdt), .lane_rdt(p0_lane_rdt)
    );

    tcb_port_align #(.MOD(MOD1), .AW(AW)) align1 (
        .tcb(tcb), .rst_n(rst_n),
        .vld(p1_vld), .wen(p1_wen), .adr(p1_adr), .siz(p1_siz), .byt(p1_byt), .wdt(p1_wdt),
        .rdt(p1_rdt),
        .req(p1_req), .wen_o(p1_lwen), .lane_en(p1_lane_en), .lane_row(p1_lane_row),
        .lane_wdt(p1_lane_wdt), .lane_rdt(p1_lane_rdt)
    );

    // shared storage, err goes straight out to the bus
    tcb_byte_bank #(.SIZE(SIZE), .AW(AW), .WRM(WRM)) bank (
        .tcb(tcb), .rst_n(rst_n),
        .p0_req(p0_req), .p0_wen(p0_lwen), .p0_lane_en(p0_lane_en),
        .p0_lane_row(p0_lane_row), .p0_lane_wdt(p0_lane_wdt),
        .p0_lane_rdt(p0_lane_rdt), .p0_err(p0_err),
        .p1_req(p1_req), .p1_wen(p1_lwen), .p1_lane_en(p1_lane_en),
        .p1_lane_row(p1_lane_row), .p1_lane_wdt(p1_lane_wdt),
        .p1_lane_rdt(p1_lane_rdt), .p1_err(p1_err)
    );

endmodule : tcb_lite_mem

//--- design/tcb_mem_pkg.sv
// package: lane count, byte and word widths, transfer size and port mode enums
package tcb_mem_pkg;

    //////////////////////////////
    // bus geometry
    //////////////////////////////

    // byte lanes in one bus word
    localparam int unsigned BYT = 4;

    // bits in one byte lane
    localparam int unsigned BW = 8;

    // full data word width
    localparam int unsigned DW = BYT * BW;

    // width of a lane index, log2 of the lane count
    localparam int unsigned LANE_W = $clog2(BYT);

    //////////////////////////////
    // request encodings
    //////////////////////////////

    // log2 of the transfer size in bytes
    // code 3 would be a double word, not supported on a 32-bit bus
    typedef enum logic [1:0] {
        SIZ_BYTE = 2'd0,
        SIZ_HALF = 2'd1,
        SIZ_WORD = 2'd2
    } tcb_siz_t;

    // port addressing mode
    // log size: the request carries siz, bytes counted from adr
    // byte enable: the request carries a lane mask in byt
    typedef enum logic {
        MODE_LOG_SIZE = 1'b0,
        MODE_BYTE_ENA = 1'b1
    } tcb_mode_t;

endpackage : tcb_mem_pkg

//--- design/tcb_port_align.sv
// module tcb_port_align: lane request aligner and read data realigner for one port
module tcb_port_align import tcb_mem_pkg::*; #(
    // addressing mode of this port
    parameter tcb_mode_t   MOD = MODE_LOG_SIZE,
    // byte address width
    parameter int unsigned AW  = 8
) (
    input  logic                          tcb,
    input  logic                          rst_n,
    // bus request
    input  logic                          vld,
    input  logic                          wen,
    input  logic [AW-1:0]                 adr,
    input  tcb_siz_t                      siz,
    input  logic [BYT-1:0]                byt,
    input  logic [DW-1:0]                 wdt,
    // bus response data
    output logic [DW-1:0]                 rdt,
    // lane request toward the bank
    output logic                          req,
    output logic                          wen_o,
    output logic [BYT-1:0]                lane_en,
    output logic [BYT-1:0][AW-LANE_W-1:0] lane_row,
    output logic [BYT-1:0][BW-1:0]        lane_wdt,
    // registered lane bytes from the bank
    input  logic [BYT-1:0][BW-1:0]        lane_rdt
);

    // row address width
    localparam int unsigned RW = AW - LANE_W;

    // start lane and start row of the request
    logic [LANE_W-1:0] off;
    logic [RW-1:0]     row;

    // state captured at a read transfer, used one cycle later
    logic [LANE_W-1:0] rd_off;
    logic [BYT-1:0]    rd_en;

    //////////////////////////////
    // request path
    //////////////////////////////

    assign off = adr[LANE_W-1:0];
    assign row = adr[AW-1:LANE_W];

    // no back-pressure, every vld cycle is a transfer
    assign req   = vld;
    assign wen_o = wen;

    always_comb begin
        logic [LANE_W-1:0] idx;
        for (int l = 0; l < BYT; l++) begin
            // request byte that lands on lane l
            idx = LANE_W'(l) - off;
            if (MOD == MODE_LOG_SIZE) begin
                // first 2**siz request bytes are active
                lane_en[l]  = int'(idx) < (1 << int'(siz));
                // size mode data is packed from byte 0, rotate by start lane
                lane_wdt[l] = wdt[BW*idx +: BW];
            end else begin
                // mask and data are already in lane order
                lane_en[l]  = byt[l];
                lane_wdt[l] = wdt[BW*l +: BW];
            end
            // lanes below the start lane wrapped past the word boundary
            // so they sit in the next row, wrapping at the top of memory
            lane_row[l] = (LANE_W'(l) < off) ? row + RW'(1) : row;
        end
    end

    //////////////////////////////
    // response path
    //////////////////////////////

    // remember how the read was spread over the lanes
    // writes leave this alone, so the last read response holds
    always_ff @(posedge tcb or negedge rst_n) begin
        if (!rst_n) begin
            rd_off <= '0;
            rd_en  <= '0;
        end else if (vld && !wen) begin
            rd_off <= off;
            rd_en  <= lane_en;
        end
    end

    // rotate lane bytes back to request order, inactive bytes read zero
    always_comb begin
        logic [LANE_W-1:0] lane;
        for (int b = 0; b < BYT; b++) begin
            if (MOD == MODE_LOG_SIZE) begin
                lane = rd_off + LANE_W'(b);
            end else begin
                lane = LANE_W'(b);
            end
            rdt[BW*b +: BW] = rd_en[lane] ? lane_rdt[lane] : '0;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // a size-mode port only ever carries byte, half or word transfers
    siz_range: assert property (
        @(posedge tcb) disable iff (!rst_n)
        (vld && (MOD == MODE_LOG_SIZE)) |-> (siz <= SIZ_WORD)
    ) else $error("size-mode transfer wider than a word");

endmodule : tcb_port_align

//--- sources.f
design/tcb_mem_pkg.sv
design/tcb_port_align.sv
design/tcb_byte_bank.sv
design/tcb_lite_mem.sv
bench/tcb_mem_clk.sv
bench/tcb_mem_tb.sv
